// File: sobel_settings.svh
`ifndef SOBEL_SETTINGS_SVH
`define SOBEL_SETTINGS_SVH

// frame geometry with four pixels per word
`define SOBEL_ROW_WORDS 4
`define SOBEL_ROWS 8

// data widths
`define SOBEL_PIX_W 8
`define SOBEL_WORD_W 32

`endif

// File: sobel_pkg.sv
`include "sobel_settings.svh"

package sobel_pkg;

	typedef logic [`SOBEL_PIX_W-1:0] pixel_t;
	typedef logic [`SOBEL_WORD_W-1:0] word_t;
	typedef logic [$clog2(`SOBEL_ROW_WORDS * `SOBEL_ROWS)-1:0] addr_t;
	typedef logic signed [10:0] grad_t; // holds +/-1020

	typedef enum logic [3:0]
	{
		ST_IDLE,
		ST_CLEAR_ROW,
		ST_READ_PREV,
		ST_READ_CUR,
		ST_READ_NEXT,
		ST_LOAD_ROWS,
		ST_SHIFT,
		ST_WRITE,
		ST_NEXT_COL,
		ST_FINISH
	} ctrl_state_t;

endpackage

// File: sobel_ctrl_if.sv
`timescale 1ns/1ps

interface sobel_ctrl_if;
	import sobel_pkg::*;

	logic pr_load;
	logic cr_load;
	logic nr_load;
	logic rows_load;
	logic shift_en;
	logic set_z;
	logic zero_row; // border row forces zero write data
	word_t rdata; // engine read data from frame_mem

	modport ctrl
	(
		output pr_load, cr_load, nr_load, rows_load, shift_en, set_z, zero_row
	);

	modport dp
	(
		input pr_load, cr_load, nr_load, rows_load, shift_en, set_z, rdata
	);

endinterface

// File: frame_mem.sv
`timescale 1ns/1ps
`include "sobel_settings.svh"

module frame_mem
(
	input logic clk,
	input logic src_we,
	input sobel_pkg::addr_t src_addr,
	input sobel_pkg::word_t src_wdata,
	input sobel_pkg::addr_t eng_raddr,
	output sobel_pkg::word_t eng_rdata,
	input logic eng_we,
	input sobel_pkg::addr_t eng_waddr,
	input sobel_pkg::word_t eng_wdata,
	input sobel_pkg::addr_t res_addr,
	output sobel_pkg::word_t res_rdata
);
	import sobel_pkg::*;

	localparam int DEPTH = `SOBEL_ROW_WORDS * `SOBEL_ROWS;

	word_t src_mem [DEPTH];
	word_t res_mem [DEPTH];

	always_ff @(posedge clk)
	begin
		if (src_we)
			src_mem[src_addr] <= src_wdata; // host fills the frame
		eng_rdata <= src_mem[eng_raddr];
	end

	always_ff @(posedge clk)
	begin
		if (eng_we)
			res_mem[eng_waddr] <= eng_wdata;
		res_rdata <= res_mem[res_addr]; // host readback
	end

	a_src_addr: assert property (@(posedge clk) src_we |-> int'(src_addr) < DEPTH)
		else $error("source write past end of frame");
	a_res_addr: assert property (@(posedge clk) eng_we |-> int'(eng_waddr) < DEPTH)
		else $error("result write past end of frame");

endmodule

// File: sobel_datapath.sv
`timescale 1ns/1ps
`include "sobel_settings.svh"

module sobel_datapath
(
	input logic clk,
	input logic rst_n,
	sobel_ctrl_if.dp ctl,
	output sobel_pkg::word_t out_word
);
	import sobel_pkg::*;

	localparam int PW = `SOBEL_PIX_W;
	localparam int WW = `SOBEL_WORD_W;

	word_t pr;
	word_t cr;
	word_t nr;
	word_t prr;
	word_t crr;
	word_t nrr;
	pixel_t win [3][3]; // [row top/mid/bot][col left/mid/right]
	grad_t gx;
	grad_t gy;
	logic [11:0] mag_sum;
	pixel_t mag;
	pixel_t pipe [6];

	function automatic grad_t ext(input pixel_t p);
		return grad_t'(p);
	endfunction

	function automatic logic [10:0] mag_of(input grad_t g);
		return g[10] ? 11'(-g) : 11'(g);
	endfunction

	always_ff @(posedge clk)
	begin
		if (ctl.pr_load)
			pr <= ctl.rdata;
		if (ctl.cr_load)
			cr <= ctl.rdata;
		if (ctl.nr_load)
			nr <= ctl.rdata;
	end

	always_ff @(posedge clk)
	begin
		if (ctl.rows_load)
		begin
			prr <= pr;
			crr <= cr;
			nrr <= nr;
		end
		else if (ctl.shift_en)
		begin
			prr <= {prr[WW-PW-1:0], PW'(0)}; // leftmost pixel leaves first
			crr <= {crr[WW-PW-1:0], PW'(0)};
			nrr <= {nrr[WW-PW-1:0], PW'(0)};
		end
	end

	always_ff @(posedge clk)
	begin
		if (ctl.shift_en)
		begin
			win[0][2] <= prr[WW-1 -: PW];
			win[1][2] <= crr[WW-1 -: PW];
			win[2][2] <= nrr[WW-1 -: PW];
			for (int r = 0; r < 3; r++)
			begin
				win[r][1] <= win[r][2];
				win[r][0] <= win[r][1];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (ctl.shift_en)
		begin
			gx <= (ext(win[0][2]) - ext(win[0][0]))
				+ ((ext(win[1][2]) - ext(win[1][0])) <<< 1)
				+ (ext(win[2][2]) - ext(win[2][0]));
			gy <= (ext(win[0][0]) + (ext(win[0][1]) <<< 1) + ext(win[0][2]))
				- (ext(win[2][0]) + (ext(win[2][1]) <<< 1) + ext(win[2][2]));
		end
	end

	assign mag_sum = {1'b0, mag_of(gx)} + {1'b0, mag_of(gy)};

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			mag <= '0;
		else if (ctl.set_z)
			mag <= '0; // border column
		else if (ctl.shift_en)
			mag <= pixel_t'(mag_sum >> 3);
	end

	always_ff @(posedge clk)
	begin
		if (ctl.shift_en)
		begin
			pipe[0] <= mag;
			for (int i = 1; i < 6; i++)
				pipe[i] <= pipe[i-1];
		end
	end

	// oldest stage is the leftmost pixel of the group
	assign out_word = {pipe[5], pipe[4], pipe[3], pipe[2]};

	a_load_shift: assert property (@(posedge clk) disable iff (!rst_n)
		!(ctl.rows_load && ctl.shift_en))
		else $error("rows_load and shift_en in the same cycle");
	a_mag_range: assert property (@(posedge clk) disable iff (!rst_n)
		ctl.shift_en |-> (mag_sum >> 3) <= 12'd255)
		else $error("magnitude above 255");

endmodule

// File: sobel_ctrl.sv
`timescale 1ns/1ps
`include "sobel_settings.svh"

module sobel_ctrl
(
	input logic clk,
	input logic rst_n,
	input logic start_valid,
	output logic start_ready,
	output logic done,
	sobel_ctrl_if.ctrl ctl,
	output sobel_pkg::addr_t eng_raddr,
	output logic eng_we,
	output sobel_pkg::addr_t eng_waddr
);
	import sobel_pkg::*;

	localparam int ROW_W = $clog2(`SOBEL_ROWS);
	localparam int COL_W = $clog2(`SOBEL_ROW_WORDS + 2);
	localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(`SOBEL_ROWS - 1);
	localparam logic [ROW_W-1:0] PEN_ROW = ROW_W'(`SOBEL_ROWS - 2);
	localparam logic [COL_W-1:0] LAST_GRP = COL_W'(`SOBEL_ROW_WORDS - 1);
	localparam logic [COL_W-1:0] EDGE_GRP = COL_W'(`SOBEL_ROW_WORDS);
	localparam logic [COL_W-1:0] FLUSH_GRP = COL_W'(`SOBEL_ROW_WORDS + 1);
	localparam addr_t ROW_STEP = addr_t'(`SOBEL_ROW_WORDS);

	ctrl_state_t state;
	logic [ROW_W-1:0] row;
	logic [COL_W-1:0] col; // runs two groups past the row for pipeline flush
	logic [COL_W-1:0] wr_col;
	logic [1:0] sc; // shift within group
	logic ld_phase; // second cycle of LOAD_ROWS
	logic row_end;
	addr_t row_base;

	assign row_end = (state == ST_CLEAR_ROW && col == LAST_GRP)
		|| (state == ST_WRITE && col == FLUSH_GRP);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= ST_IDLE;
			row <= '0;
			col <= '0;
			sc <= '0;
			ld_phase <= 1'b0;
		end
		else if (row_end)
		begin
			col <= '0;
			sc <= '0;
			if (row == LAST_ROW)
				state <= ST_FINISH;
			else
			begin
				row <= row + 1'b1;
				state <= (row == PEN_ROW) ? ST_CLEAR_ROW : ST_READ_PREV;
			end
		end
		else
		begin
			case (state)
				ST_IDLE:
					if (start_valid)
					begin
						row <= '0;
						col <= '0;
						state <= ST_CLEAR_ROW; // row 0 is border
					end
				ST_CLEAR_ROW:
					col <= col + 1'b1;
				ST_READ_PREV:
					state <= ST_READ_CUR;
				ST_READ_CUR:
					state <= ST_READ_NEXT;
				ST_READ_NEXT:
					state <= ST_LOAD_ROWS;
				ST_LOAD_ROWS:
					if (!ld_phase)
						ld_phase <= 1'b1;
					else
					begin
						ld_phase <= 1'b0;
						sc <= '0;
						state <= ST_SHIFT;
					end
				ST_SHIFT:
				begin
					sc <= sc + 1'b1;
					if (sc == 2'd1 && col >= COL_W'(2))
						state <= ST_WRITE; // group col-2 now aligned
					else if (sc == 2'd3)
						state <= ST_NEXT_COL;
				end
				ST_WRITE:
					state <= ST_SHIFT;
				ST_NEXT_COL:
				begin
					col <= col + 1'b1;
					state <= (col < LAST_GRP) ? ST_READ_PREV : ST_SHIFT;
				end
				ST_FINISH:
					state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	assign start_ready = (state == ST_IDLE);
	assign done = (state == ST_FINISH);

	assign ctl.pr_load = (state == ST_READ_CUR);
	assign ctl.cr_load = (state == ST_READ_NEXT);
	assign ctl.nr_load = (state == ST_LOAD_ROWS) && !ld_phase;
	assign ctl.rows_load = (state == ST_LOAD_ROWS) && ld_phase;
	assign ctl.shift_en = (state == ST_SHIFT);
	// zero the magnitudes of the first and last pixel of the row
	assign ctl.set_z = (state == ST_SHIFT)
		&& ((col == '0 && sc == 2'd3) || (col == EDGE_GRP && sc == 2'd2));
	assign ctl.zero_row = (state == ST_CLEAR_ROW);

	assign row_base = addr_t'(row * `SOBEL_ROW_WORDS);

	always_comb
	begin
		case (state)
			ST_READ_PREV:
				eng_raddr = row_base - ROW_STEP + addr_t'(col);
			ST_READ_NEXT:
				eng_raddr = row_base + ROW_STEP + addr_t'(col);
			default:
				eng_raddr = row_base + addr_t'(col);
		endcase
	end

	assign wr_col = (state == ST_WRITE) ? col - COL_W'(2) : col;
	assign eng_we = (state == ST_CLEAR_ROW) || (state == ST_WRITE);
	assign eng_waddr = row_base + addr_t'(wr_col);

endmodule

// File: sobel_top.sv
`timescale 1ns/1ps

module sobel_top
(
	input logic clk,
	input logic rst_n,
	input logic src_we,
	input sobel_pkg::addr_t src_addr,
	input sobel_pkg::word_t src_wdata,
	input logic start_valid,
	output logic start_ready,
	output logic done,
	input sobel_pkg::addr_t res_addr,
	output sobel_pkg::word_t res_rdata
);
	import sobel_pkg::*;

	addr_t eng_raddr;
	addr_t eng_waddr;
	logic eng_we;
	word_t eng_wdata;
	word_t out_word;

	sobel_ctrl_if ctl ();

	frame_mem u_mem
	(
		.clk(clk),
		.src_we(src_we),
		.src_addr(src_addr),
		.src_wdata(src_wdata),
		.eng_raddr(eng_raddr),
		.eng_rdata(ctl.rdata),
		.eng_we(eng_we),
		.eng_waddr(eng_waddr),
		.eng_wdata(eng_wdata),
		.res_addr(res_addr),
		.res_rdata(res_rdata)
	);

	sobel_ctrl u_ctrl
	(
		.clk(clk),
		.rst_n(rst_n),
		.start_valid(start_valid),
		.start_ready(start_ready),
		.done(done),
		.ctl(ctl.ctrl),
		.eng_raddr(eng_raddr),
		.eng_we(eng_we),
		.eng_waddr(eng_waddr)
	);

	sobel_datapath u_dp
	(
		.clk(clk),
		.rst_n(rst_n),
		.ctl(ctl.dp),
		.out_word(out_word)
	);

	assign eng_wdata = ctl.zero_row ? '0 : out_word; // top and bottom rows

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock
#(
	parameter int PERIOD = 4,
	parameter int RESET_CYCLES = 3
)
(
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1; // release away from the edge
	end

	always #(PERIOD / 2) clk = ~clk;

endmodule

// File: tb_sobel.sv
`timescale 1ns/1ps
`include "sobel_settings.svh"

module tb_sobel;
	import sobel_pkg::*;

	localparam int RW = `SOBEL_ROW_WORDS;
	localparam int COLS = `SOBEL_ROW_WORDS * 4;
	localparam int ROWS = `SOBEL_ROWS;
	localparam int WORDS = `SOBEL_ROW_WORDS * `SOBEL_ROWS;
	localparam int RUN_LIMIT = 40 * COLS * ROWS; // cycles per test
	localparam int NUM_TESTS = 10;

	logic clk;
	logic rst_n;
	logic src_we;
	addr_t src_addr;
	word_t src_wdata;
	logic start_valid;
	logic start_ready;
	logic done;
	addr_t res_addr;
	word_t res_rdata;

	int img [ROWS][COLS]; // host copy of the source frame
	logic [31:0] rng = 32'd64;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_err = 0;
	string test_name = "none";
	event check_req;
	event check_ack;

	tb_clock #(.PERIOD(4), .RESET_CYCLES(3)) u_clock (.clk(clk), .rst_n(rst_n));

	sobel_top DUT
	(
		.clk(clk),
		.rst_n(rst_n),
		.src_we(src_we),
		.src_addr(src_addr),
		.src_wdata(src_wdata),
		.start_valid(start_valid),
		.start_ready(start_ready),
		.done(done),
		.res_addr(res_addr),
		.res_rdata(res_rdata)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// expected output pixel with a zero frame border
	function automatic int sobel_ref(input int r, input int c);
		int gx;
		int gy;
		int s;
		if (r == 0 || r == ROWS - 1 || c == 0 || c == COLS - 1)
			return 0;
		gx = img[r-1][c+1] - img[r-1][c-1] + 2 * (img[r][c+1] - img[r][c-1])
			+ img[r+1][c+1] - img[r+1][c-1];
		gy = img[r-1][c-1] + 2 * img[r-1][c] + img[r-1][c+1]
			- img[r+1][c-1] - 2 * img[r+1][c] - img[r+1][c+1];
		s = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
		return s / 8;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			test_err++;
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic fill_frame(input int kind);
		for (int r = 0; r < ROWS; r++)
			for (int c = 0; c < COLS; c++)
			begin
				case (kind)
					0: img[r][c] = 90;
					1: img[r][c] = (c < 7) ? 20 : 200; // vertical step
					2: img[r][c] = (r < 4) ? 30 : 220; // horizontal step
					3: img[r][c] = ((r / 2 + c / 2) % 2 == 1) ? 255 : 0; // 2x2 squares
					default:
					begin
						rng = xorshift32(rng);
						img[r][c] = int'(rng[7:0]);
					end
				endcase
			end
	endtask

	task automatic load_frame();
		int r;
		int c;
		for (int a = 0; a < WORDS; a++)
		begin
			r = a / RW;
			c = (a % RW) * 4;
			src_we = 1'b1;
			src_addr = addr_t'(a);
			src_wdata = {pixel_t'(img[r][c]), pixel_t'(img[r][c+1]),
				pixel_t'(img[r][c+2]), pixel_t'(img[r][c+3])};
			step();
		end
		src_we = 1'b0;
	endtask

	// hold keeps start_valid high for the whole run
	task automatic run_frame(input bit hold);
		bit accepted;
		int cycles;
		start_valid = 1'b1;
		accepted = 1'b0;
		while (!accepted)
		begin
			accepted = start_ready;
			step();
		end
		if (!hold)
			start_valid = 1'b0;
		cycles = 0;
		while (!done && cycles < RUN_LIMIT)
		begin
			if (hold)
				check_value({test_name, " start_ready in run"}, 32'd0, 32'(start_ready));
			step();
			cycles++;
		end
		start_valid = 1'b0;
		if (!done)
		begin
			errors++;
			test_err++;
			$display("%s: no done pulse after %0d cycles", test_name, RUN_LIMIT);
		end
		step();
		check_value({test_name, " done width"}, 32'd0, 32'(done));
		check_value({test_name, " start_ready after run"}, 32'd1, 32'(start_ready));
	endtask

	task automatic run_test(input string name, input int kind, input bit hold);
		test_name = name;
		test_err = 0;
		fill_frame(kind);
		load_frame();
		run_frame(hold);
		-> check_req;
		@(check_ack);
		tests++;
		$display("test %s: %0d errors", name, test_err);
	endtask

	// reads back the result frame after each run
	initial
	begin
		word_t exp_word;
		res_addr = '0;
		forever
		begin
			@(check_req);
			for (int a = 0; a < WORDS; a++)
			begin
				res_addr = addr_t'(a);
				step();
				for (int k = 0; k < 4; k++)
					exp_word[31-8*k -: 8] = pixel_t'(sobel_ref(a / RW, (a % RW) * 4 + k));
				check_value($sformatf("%s word %0d", test_name, a), exp_word, res_rdata);
			end
			-> check_ack;
		end
	end

	initial
	begin
		src_we = 1'b0;
		src_addr = '0;
		src_wdata = '0;
		start_valid = 1'b0;
		@(posedge rst_n);
		step();
		test_name = "reset";
		check_value("start_ready after reset", 32'd1, 32'(start_ready));
		check_value("done after reset", 32'd0, 32'(done));
		tests++;
		$display("test reset: %0d errors", test_err);
		run_test("flat", 0, 1'b0);
		run_test("vstep", 1, 1'b0);
		run_test("hstep", 2, 1'b0);
		run_test("random0", 4, 1'b0);
		run_test("random1", 4, 1'b0);
		run_test("random2", 4, 1'b0);
		run_test("held_start", 4, 1'b1);
		run_test("back_to_back", 4, 1'b1);
		run_test("checker", 3, 1'b0);
		$display("tests %0d checks %0d errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin
		repeat (NUM_TESTS * RUN_LIMIT) @(posedge clk);
		$display("watchdog: run still going after %0d cycles", NUM_TESTS * RUN_LIMIT);
		$display("Test failed");
		$finish;
	end

endmodule

// File: sobel.f
+incdir+.
sobel_pkg.sv
sobel_ctrl_if.sv
frame_mem.sv
sobel_datapath.sv
sobel_ctrl.sv
sobel_top.sv
tb_clock.sv
tb_sobel.sv

// File: Makefile
SIM_LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_sobel with Verilator and run it"
	@echo "  clean  remove obj_dir and $(SIM_LOG)"

test:
	verilator --binary --timing --timescale 1ns/1ps -f sobel.f --top-module tb_sobel -o tb_sobel
	./obj_dir/tb_sobel > $(SIM_LOG) 2>&1 || (cat $(SIM_LOG); exit 1)
	@cat $(SIM_LOG)
	@if grep -q "Test failed" $(SIM_LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(SIM_LOG)
